// File: ring_cfg_pkg.sv
/*
  Ring-wide constants
  Flit and node ID widths, header payload width
  Default values for the ring node parameters
*/
`default_nettype none

package ring_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // Link widths
  ////////////////////////////////////////////////////////////
  localparam int unsigned FLIT_W    = 32;   // One flit on every link
  localparam int unsigned NODE_ID_W = 8;    // Dest and source IDs
  localparam int unsigned HDR_PLD_W = FLIT_W - 2 * NODE_ID_W; // Header payload bits

  ////////////////////////////////////////////////////////////
  // Node defaults
  ////////////////////////////////////////////////////////////
  localparam int unsigned DEF_NODE_ID    = 3;  // Address of this node
  localparam int unsigned DEF_FIFO_DEPTH = 4;  // Power of two, 2 or more

endpackage

`default_nettype wire

// File: flit_pkg.sv
/*
  Flit format types
  Header struct with destination, source and payload fields
  Packed union giving a header view and a raw view of one flit
*/
`default_nettype none

package flit_pkg;

  import ring_cfg_pkg::*;

  ////////////////////////////////////////////////////////////
  // Header flit layout
  ////////////////////////////////////////////////////////////
  // First flit of a worm, MSB first
  typedef struct packed {
    logic [NODE_ID_W-1:0] dst;  // Bits 31..24
    logic [NODE_ID_W-1:0] src;  // Bits 23..16
    logic [HDR_PLD_W-1:0] pld;  // Bits 15..0
  } flit_hdr_t;

  ////////////////////////////////////////////////////////////
  // One flit, two readings
  ////////////////////////////////////////////////////////////
  // Demux decodes hdr on the first flit
  // FIFO and mux only ever move raw
  typedef union packed {
    flit_hdr_t         hdr;  // Header view
    logic [FLIT_W-1:0] raw;  // Body flits and transport
  } flit_t;

endpackage

`default_nettype wire

// File: flit_if.sv
/*
  One valid/ready flit link
  Data, last, valid and ready with source and sink modports
*/
`default_nettype none

interface flit_if;

  import flit_pkg::*;

  flit_t data;   // Current flit
  logic  last;   // Final flit of the worm
  logic  valid;  // Source has a flit
  logic  ready;  // Sink takes it this cycle

  // Driving side of the link
  modport src (output data, output last, output valid, input ready);

  // Receiving side
  modport dst (input data, input last, input valid, output ready);

endinterface

`default_nettype wire

// File: ring_demux.sv
/*
  Ring input demultiplexer
  Decodes the header flit of each upstream worm
  Steers the whole worm to the eject port or to pass-through
*/
`default_nettype none

module ring_demux #(
  parameter int unsigned NODE_ID = ring_cfg_pkg::DEF_NODE_ID
) (
  input  wire logic          clk,
  input  wire logic          rst,

  // Upstream ring
  input  wire flit_pkg::flit_t in_data,
  input  wire logic          in_last,
  input  wire logic          in_valid,
  output logic               in_ready,

  // Local eject
  output flit_pkg::flit_t    eject_data,
  output logic               eject_last,
  output logic               eject_valid,
  input  wire logic          eject_ready,

  // Pass-through toward the mux
  flit_if.src                pass_o
);

  import ring_cfg_pkg::*;

  ////////////////////////////////////////////////////////////
  // Worm state
  ////////////////////////////////////////////////////////////
  localparam logic [1:0] W_IDLE  = 2'd0;  // Next flit is a header
  localparam logic [1:0] W_EJECT = 2'd1;  // Worm open toward eject
  localparam logic [1:0] W_PASS  = 2'd2;  // Worm open toward pass

  logic [1:0] worm;
  logic [1:0] worm_nxt;
  logic       hdr_hit;    // Header names this node
  logic       sel_eject;  // Current flit goes to eject
  logic       in_fire;

  // Only meaningful on a header flit
  assign hdr_hit = (in_data.hdr.dst == NODE_ID_W'(NODE_ID));

  // Live decode when idle, held choice inside a worm
  assign sel_eject = (worm == W_IDLE) ? hdr_hit : (worm == W_EJECT);

  ////////////////////////////////////////////////////////////
  // Steering, zero latency
  ////////////////////////////////////////////////////////////
  assign eject_data   = in_data;
  assign eject_last   = in_last;
  assign eject_valid  = in_valid & sel_eject;

  assign pass_o.data  = in_data;
  assign pass_o.last  = in_last;
  assign pass_o.valid = in_valid & ~sel_eject;

  assign in_ready = sel_eject ? eject_ready : pass_o.ready;  // Selected sink only
  assign in_fire  = in_valid & in_ready;

  ////////////////////////////////////////////////////////////
  // Worm lock
  ////////////////////////////////////////////////////////////
  always_comb begin
    worm_nxt = worm;
    if (worm == W_IDLE) begin
      // Single-flit worm taken now needs no lock
      if (in_valid && !(in_last && in_ready)) begin
        worm_nxt = sel_eject ? W_EJECT : W_PASS;
      end
    end else if (in_fire && in_last) begin
      worm_nxt = W_IDLE;  // Tail gone
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      worm <= W_IDLE;
    end else begin
      worm <= worm_nxt;
    end
  end

endmodule

`default_nettype wire

// File: inject_fifo.sv
/*
  Local injection FIFO
  Circular buffer of flits with their last bits
  Simultaneous write and read, head shown whenever not empty
*/
`default_nettype none

module inject_fifo #(
  parameter int unsigned FIFO_DEPTH = ring_cfg_pkg::DEF_FIFO_DEPTH
) (
  input  wire logic            clk,
  input  wire logic            rst,

  // Local endpoint side
  input  wire flit_pkg::flit_t wr_data,
  input  wire logic            wr_last,
  input  wire logic            wr_valid,
  output logic                 wr_ready,

  // Toward the ring mux
  flit_if.src                  rd_o
);

  import flit_pkg::*;

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);      // Depth is a power of two
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);  // Holds 0..FIFO_DEPTH

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////
  flit_t mem_data [FIFO_DEPTH];
  logic  mem_last [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;  // Flits held
  logic             wr_fire;
  logic             rd_fire;

  assign wr_ready = (count != CNT_W'(FIFO_DEPTH));  // Low when full
  assign wr_fire  = wr_valid & wr_ready;

  // Head entry straight from the array
  assign rd_o.valid = (count != '0);
  assign rd_o.data  = mem_data[rd_ptr];
  assign rd_o.last  = mem_last[rd_ptr];
  assign rd_fire    = rd_o.valid & rd_o.ready;

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem_data[wr_ptr] <= wr_data;
      mem_last[wr_ptr] <= wr_last;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
      end
      if (rd_fire) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_fire, rd_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

// File: ring_mux.sv
/*
  Ring output multiplexer
  Wormhole arbiter merging pass-through and injected worms
  Pass traffic first at worm boundaries, lock until the tail
*/
`default_nettype none

module ring_mux (
  input  wire logic clk,
  input  wire logic rst,

  flit_if.dst       pass_i,  // From the demux
  flit_if.dst       inj_i,   // From the injection FIFO

  // Downstream ring
  output flit_pkg::flit_t out_data,
  output logic            out_last,
  output logic            out_valid,
  input  wire logic       out_ready
);

  ////////////////////////////////////////////////////////////
  // Grant state
  ////////////////////////////////////////////////////////////
  localparam logic [1:0] NO_WORM  = 2'd0;
  localparam logic [1:0] WORM_PAS = 2'd1;  // Locked to pass
  localparam logic [1:0] WORM_INJ = 2'd2;  // Locked to inject

  logic [1:0] state;
  logic [1:0] state_nxt;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= NO_WORM;
    end else begin
      state <= state_nxt;
    end
  end

  ////////////////////////////////////////////////////////////
  // Arbitration and forwarding
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_nxt    = state;
    out_valid    = 1'b0;
    out_data     = pass_i.data;  // Don't care while invalid
    out_last     = pass_i.last;
    pass_i.ready = 1'b0;
    inj_i.ready  = 1'b0;

    case (state)
      NO_WORM: begin
        if (pass_i.valid) begin
          // Ring traffic wins
          out_valid    = 1'b1;
          pass_i.ready = out_ready;
          if (out_ready && !pass_i.last) begin
            state_nxt = WORM_PAS;
          end
        end else if (inj_i.valid) begin
          out_data    = inj_i.data;
          out_last    = inj_i.last;
          out_valid   = 1'b1;
          inj_i.ready = out_ready;
          if (out_ready && !inj_i.last) begin
            state_nxt = WORM_INJ;
          end
        end
      end
      WORM_PAS: begin
        out_valid    = pass_i.valid;
        pass_i.ready = out_ready;
        if (pass_i.valid && out_ready && pass_i.last) begin
          state_nxt = NO_WORM;  // Tail accepted
        end
      end
      WORM_INJ: begin
        out_data    = inj_i.data;
        out_last    = inj_i.last;
        out_valid   = inj_i.valid;
        inj_i.ready = out_ready;
        if (inj_i.valid && out_ready && inj_i.last) begin
          state_nxt = NO_WORM;
        end
      end
      default: begin
        state_nxt = NO_WORM;  // Unused code
      end
    endcase
  end

endmodule

`default_nettype wire

// File: ring_node.sv
/*
  Ring node top level
  Demux for ejection, FIFO for local injection, mux onto the ring
*/
`default_nettype none

module ring_node #(
  parameter int unsigned NODE_ID    = ring_cfg_pkg::DEF_NODE_ID,
  parameter int unsigned FIFO_DEPTH = ring_cfg_pkg::DEF_FIFO_DEPTH
) (
  input  wire logic                            clk,
  input  wire logic                            rst,

  // Upstream ring
  input  wire logic [ring_cfg_pkg::FLIT_W-1:0] ring_in_data,
  input  wire logic                            ring_in_last,
  input  wire logic                            ring_in_valid,
  output logic                                 ring_in_ready,

  // Downstream ring
  output logic [ring_cfg_pkg::FLIT_W-1:0]      ring_out_data,
  output logic                                 ring_out_last,
  output logic                                 ring_out_valid,
  input  wire logic                            ring_out_ready,

  // Local injection
  input  wire logic [ring_cfg_pkg::FLIT_W-1:0] local_in_data,
  input  wire logic                            local_in_last,
  input  wire logic                            local_in_valid,
  output logic                                 local_in_ready,

  // Local ejection
  output logic [ring_cfg_pkg::FLIT_W-1:0]      eject_data,
  output logic                                 eject_last,
  output logic                                 eject_valid,
  input  wire logic                            eject_ready
);

  ////////////////////////////////////////////////////////////
  // Internal links
  ////////////////////////////////////////////////////////////
  flit_if pass_if ();  // Demux to mux
  flit_if inj_if ();   // FIFO to mux

  ring_demux #(
    .NODE_ID     (NODE_ID)
  ) demux_i (
    .clk         (clk),
    .rst         (rst),
    .in_data     (ring_in_data),
    .in_last     (ring_in_last),
    .in_valid    (ring_in_valid),
    .in_ready    (ring_in_ready),
    .eject_data  (eject_data),
    .eject_last  (eject_last),
    .eject_valid (eject_valid),
    .eject_ready (eject_ready),
    .pass_o      (pass_if)
  );

  inject_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) fifo_i (
    .clk        (clk),
    .rst        (rst),
    .wr_data    (local_in_data),
    .wr_last    (local_in_last),
    .wr_valid   (local_in_valid),
    .wr_ready   (local_in_ready),
    .rd_o       (inj_if)
  );

  ring_mux mux_i (
    .clk       (clk),
    .rst       (rst),
    .pass_i    (pass_if),
    .inj_i     (inj_if),
    .out_data  (ring_out_data),
    .out_last  (ring_out_last),
    .out_valid (ring_out_valid),
    .out_ready (ring_out_ready)
  );

endmodule

`default_nettype wire

// File: ring_node_checker.sv
/*
  Ring node checker
  Reference queues for eject, pass-through and injected flits
  Compares every output handshake and counts errors
*/
`default_nettype none

module ring_node_checker #(
  parameter int unsigned NODE_ID    = ring_cfg_pkg::DEF_NODE_ID,
  parameter int unsigned FIFO_DEPTH = ring_cfg_pkg::DEF_FIFO_DEPTH
) (
  input  wire logic                            clk,
  input  wire logic                            rst,
  input  wire logic [ring_cfg_pkg::FLIT_W-1:0] ring_in_data,
  input  wire logic                            ring_in_last,
  input  wire logic                            ring_in_valid,
  input  wire logic                            ring_in_ready,
  input  wire logic [ring_cfg_pkg::FLIT_W-1:0] ring_out_data,
  input  wire logic                            ring_out_last,
  input  wire logic                            ring_out_valid,
  input  wire logic                            ring_out_ready,
  input  wire logic [ring_cfg_pkg::FLIT_W-1:0] local_in_data,
  input  wire logic                            local_in_last,
  input  wire logic                            local_in_valid,
  input  wire logic                            local_in_ready,
  input  wire logic [ring_cfg_pkg::FLIT_W-1:0] eject_data,
  input  wire logic                            eject_last,
  input  wire logic                            eject_valid,
  input  wire logic                            eject_ready,
  output int unsigned                          error_count,
  output int unsigned                          pending
);

  import ring_cfg_pkg::*;

  // Entries are {last, data}
  logic [FLIT_W:0] exp_eject [$];
  logic [FLIT_W:0] exp_pass  [$];
  logic [FLIT_W:0] exp_inj   [$];  // Also the FIFO fill level

  logic        ring_open     = 1'b0;  // Ring worm in progress
  logic        ring_to_eject = 1'b0;
  logic        out_open      = 1'b0;  // ring_out worm in progress
  logic        out_from_inj  = 1'b0;
  logic        seen_input    = 1'b0;
  logic        exp_ring_ready;
  logic        exp_local_ready;
  int unsigned errs          = 0;
  int unsigned queued        = 0;

  assign error_count = errs;
  assign pending     = queued;

  task automatic compare_flit(input string port, input logic [FLIT_W:0] exp,
                              input logic [FLIT_W-1:0] data, input logic last);
    if (exp[FLIT_W-1:0] !== data) begin
      $display("error: %s_data expected %h got %h", port, exp[FLIT_W-1:0], data);
      errs++;
    end
    if (exp[FLIT_W] !== last) begin
      $display("error: %s_last expected %h got %h", port, exp[FLIT_W], last);
      errs++;
    end
  endtask

  task automatic check_eject();
    logic [FLIT_W:0] exp;
    if (exp_eject.size() == 0) begin
      $display("error: flit %h came out on eject with no worm for this node", eject_data);
      errs++;
    end else begin
      exp = exp_eject.pop_front();
      compare_flit("eject", exp, eject_data, eject_last);
    end
  endtask

  task automatic check_ring_out();
    logic [FLIT_W:0] got;
    logic [FLIT_W:0] exp;
    logic            have;
    got  = {ring_out_last, ring_out_data};
    have = 1'b1;
    if (!out_open) begin
      // Header picks the source queue
      if (exp_pass.size() != 0 && exp_pass[0] == got) begin
        out_from_inj = 1'b0;
      end else if (exp_inj.size() != 0 && exp_inj[0] == got) begin
        out_from_inj = 1'b1;
      end else begin
        $display("error: ring_out header %h matches no waiting ring or local worm",
                 ring_out_data);
        errs++;
        have = 1'b0;
      end
    end
    if (have) begin
      if (out_from_inj && exp_inj.size() != 0) begin
        exp = exp_inj.pop_front();
        compare_flit("ring_out", exp, ring_out_data, ring_out_last);
      end else if (!out_from_inj && exp_pass.size() != 0) begin
        exp = exp_pass.pop_front();
        compare_flit("ring_out", exp, ring_out_data, ring_out_last);
      end else begin
        $display("error: ring_out sent flit %h after its worm ran dry", ring_out_data);
        errs++;
      end
      out_open = !ring_out_last;  // Lock holds until the tail
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Sampling mid-cycle when all inputs have settled
  ////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    if (rst) begin
      exp_eject.delete();
      exp_pass.delete();
      exp_inj.delete();
      ring_open  = 1'b0;
      out_open   = 1'b0;
      seen_input = 1'b0;
    end else begin
      if (ring_in_valid || local_in_valid) begin
        seen_input = 1'b1;
      end
      if (!seen_input) begin  // Quiet node after reset
        if (ring_out_valid !== 1'b0) begin
          $display("error: ring_out_valid expected %h got %h", 1'b0, ring_out_valid);
          errs++;
        end
        if (eject_valid !== 1'b0) begin
          $display("error: eject_valid expected %h got %h", 1'b0, eject_valid);
          errs++;
        end
      end

      // Ready exactly while the FIFO has room, so high after reset
      exp_local_ready = (exp_inj.size() < int'(FIFO_DEPTH));
      if (local_in_ready !== exp_local_ready) begin
        $display("error: local_in_ready expected %h got %h with %0d flits held",
                 exp_local_ready, local_in_ready, exp_inj.size());
        errs++;
      end

      // Ring input before the outputs since latency is zero
      if (ring_in_valid) begin
        if (!ring_open) begin
          ring_to_eject = (ring_in_data[FLIT_W-1 -: NODE_ID_W] == NODE_ID_W'(NODE_ID));
        end
        // Eject sink, or the mux unless it is locked to a local worm
        exp_ring_ready = ring_to_eject ? eject_ready
                                       : (ring_out_ready && !(out_open && out_from_inj));
        if (ring_in_ready !== exp_ring_ready) begin
          $display("error: ring_in_ready expected %h got %h", exp_ring_ready, ring_in_ready);
          errs++;
        end
        if (ring_in_ready) begin
          if (ring_to_eject) begin
            exp_eject.push_back({ring_in_last, ring_in_data});
          end else begin
            exp_pass.push_back({ring_in_last, ring_in_data});
          end
          ring_open = !ring_in_last;
        end
      end

      if (eject_valid && eject_ready) begin
        check_eject();
      end
      if (ring_out_valid && ring_out_ready) begin
        check_ring_out();
      end

      // Local flits need a cycle in the FIFO
      if (local_in_valid && local_in_ready) begin
        exp_inj.push_back({local_in_last, local_in_data});
      end
      queued = exp_eject.size() + exp_pass.size() + exp_inj.size();
    end
  end

endmodule

`default_nettype wire

// File: tb_ring_node.sv
/*
  Testbench top for the ring node
  Clock, reset, random ring and local worms, random back-pressure
  Checker instance does all comparing and this module ends the run
*/
`default_nettype none

module tb_ring_node;

  import ring_cfg_pkg::*;

  localparam int unsigned TB_NODE_ID    = 3;
  localparam int unsigned TB_FIFO_DEPTH = 4;
  localparam int          N_WORMS       = 200;    // Per side
  localparam int          RUN_LIMIT     = 40000;  // Cycles for all stimulus
  localparam int          DRAIN_LIMIT   = 2000;   // Cycles to empty the queues

  logic              clk;
  logic              rst;
  logic [FLIT_W-1:0] ring_in_data;
  logic              ring_in_last;
  logic              ring_in_valid;
  logic              ring_in_ready;
  logic [FLIT_W-1:0] ring_out_data;
  logic              ring_out_last;
  logic              ring_out_valid;
  logic              ring_out_ready;
  logic [FLIT_W-1:0] local_in_data;
  logic              local_in_last;
  logic              local_in_valid;
  logic              local_in_ready;
  logic [FLIT_W-1:0] eject_data;
  logic              eject_last;
  logic              eject_valid;
  logic              eject_ready;

  int unsigned chk_errors;   // Mismatches seen by the checker
  int unsigned chk_pending;  // Flits still expected somewhere
  int unsigned timeouts;
  integer      seed;
  int          cycles;

  // Flits left in the open worm and worms done per sender
  int   ring_left;
  int   ring_sent;
  int   local_left;
  int   local_sent;
  logic ring_fire;
  logic local_fire;

  ring_node #(
    .NODE_ID    (TB_NODE_ID),
    .FIFO_DEPTH (TB_FIFO_DEPTH)
  ) dut_i (.*);

  ring_node_checker #(
    .NODE_ID    (TB_NODE_ID),
    .FIFO_DEPTH (TB_FIFO_DEPTH)
  ) checker_i (
    .*,
    .error_count (chk_errors),
    .pending     (chk_pending)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // One sender advanced once per cycle
  ////////////////////////////////////////////////////////////
  task automatic step_sender(
    input  logic              fired,
    input  logic              is_ring,
    inout  int                left,
    inout  int                sent,
    inout  logic              valid,
    inout  logic [FLIT_W-1:0] data,
    inout  logic              last
  );
    logic [31:0] r;
    logic [31:0] body;
    if (fired) begin
      left = left - 1;
      if (left == 0) begin
        sent = sent + 1;  // Tail taken
      end
    end
    r    = $random(seed);
    body = $random(seed);
    // A stalled flit stays put
    if (!valid || fired) begin
      if (sent < N_WORMS && r[1:0] != 2'b00) begin
        if (left == 0) begin
          left = int'(r[3:2]) + 1;  // 1 to 4 flits
          if (is_ring) begin
            data = {5'b0, r[6:4], r[15:8], body[15:0]};  // Dest 0..7
          end else begin
            data = {r[23:16], 8'h03, body[15:0]};  // Any dest and source node 3
          end
        end else begin
          data = body;
        end
        valid = 1'b1;
        last  = (left == 1);
      end else begin
        valid = 1'b0;  // Idle gap
      end
    end
  endtask

  // Sample handshakes mid-cycle and drive 10 after the edge
  task automatic drive_cycle();
    logic [31:0] r;
    @(negedge clk);
    ring_fire  = ring_in_valid && ring_in_ready;
    local_fire = local_in_valid && local_in_ready;
    @(posedge clk);
    #10;
    step_sender(ring_fire, 1'b1, ring_left, ring_sent,
                ring_in_valid, ring_in_data, ring_in_last);
    step_sender(local_fire, 1'b0, local_left, local_sent,
                local_in_valid, local_in_data, local_in_last);
    r = $random(seed);
    ring_out_ready = r[0] | r[1];  // Ready about 3 of 4 cycles
    eject_ready    = r[2] | r[3];
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    seed           = 98;
    timeouts       = 0;
    ring_left      = 0;
    ring_sent      = 0;
    local_left     = 0;
    local_sent     = 0;
    rst            = 1'b1;
    ring_in_data   = '0;
    ring_in_last   = 1'b0;
    ring_in_valid  = 1'b0;
    ring_out_ready = 1'b1;
    local_in_data  = '0;
    local_in_last  = 1'b0;
    local_in_valid = 1'b0;
    eject_ready    = 1'b1;

    repeat (5) @(posedge clk);
    #10;
    rst = 1'b0;
    repeat (3) @(posedge clk);  // Quiet window after reset

    cycles = 0;
    while ((ring_sent < N_WORMS || local_sent < N_WORMS) && cycles < RUN_LIMIT) begin
      drive_cycle();
      cycles++;
    end
    if (ring_sent < N_WORMS || local_sent < N_WORMS) begin
      $display("Timeout: stimulus stuck after %0d ring and %0d local worms",
               ring_sent, local_sent);
      timeouts++;
    end

    cycles = 0;
    while (chk_pending != 0 && cycles < DRAIN_LIMIT) begin
      drive_cycle();
      cycles++;
    end
    if (chk_pending != 0) begin
      $display("Timeout: %0d flits never came out of the node", chk_pending);
      timeouts++;
    end

    $display("Checker errors: %0d, timeouts: %0d", chk_errors, timeouts);
    if (chk_errors == 0 && timeouts == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
ring_cfg_pkg.sv
flit_pkg.sv
flit_if.sv
ring_demux.sv
inject_fifo.sv
ring_mux.sv
ring_node.sv
ring_node_checker.sv
tb_ring_node.sv

// File: Makefile
# Verilator simulation of the ring node

TOP = tb_ring_node

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f tb.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
